/* src/rab_defs.svh */
// Register-access subsystem widths and depths
// Shared by the link, bridge, bank and target port blocks

`ifndef RAB_DEFS_SVH
`define RAB_DEFS_SVH

// Register data width
`define RAB_DATA_W 32

// Register index width
// Top bit picks the bank, 0 scratch and 1 event
`define RAB_IDX_W 4

// Sequence tag carried in every flit
`define RAB_TAG_W 4

// Receive FIFO depth, also the initial credit count of a link
// Keep this a power of two so the FIFO pointers wrap for free
`define RAB_LINK_DEPTH 4

// Scratch bank size, must fill the low half of the index space
`define RAB_SCRATCH_REGS 8

`endif

/* src/rab_pkg.sv */
// Register-access subsystem types
// Client request and response records and the two views of a link flit

`include "rab_defs.svh"

package rab_pkg;

	// ****************************************
	// Client side
	// ****************************************

	// One register access from the client
	typedef struct packed {
		logic wr;
		logic [`RAB_IDX_W-1:0] idx;
		logic [`RAB_DATA_W-1:0] wdata;
	} rab_req_t;

	// Result of one access
	typedef struct packed {
		logic [`RAB_DATA_W-1:0] rdata;
		logic err;
	} rab_rsp_t;

	// ****************************************
	// Link flit
	// ****************************************

	// Request view, tag in the top bits
	typedef struct packed {
		logic [`RAB_TAG_W-1:0] tag;
		rab_req_t req;
	} rab_flit_req_t;

	// Response view
	// Request carries wr and idx where the response carries err,
	// so the pad is idx-wide to keep both views the same size
	typedef struct packed {
		logic [`RAB_TAG_W-1:0] tag;
		rab_rsp_t rsp;
		logic [`RAB_IDX_W-1:0] pad;
	} rab_flit_rsp_t;

	// One link word, read as request or response depending on direction
	typedef union packed {
		rab_flit_req_t req;
		rab_flit_rsp_t rsp;
	} rab_flit_u;

endpackage

/* src/link_tx.sv */
// Link transmitter for one direction
// Holds the credit count and launches one registered flit per send

`timescale 1ns/1ps
`include "rab_defs.svh"

module link_tx
	import rab_pkg::*;
(
	input logic rvx_port_02,
	input logic rvx_port_04,
	input logic send,
	input rab_flit_u send_flit,
	input logic credit_return,
	output logic has_credit,
	output logic flit_valid,
	output rab_flit_u flit
);

	localparam int CRED_W = $clog2(`RAB_LINK_DEPTH + 1);
	localparam logic [CRED_W-1:0] CRED_MAX = CRED_W'(`RAB_LINK_DEPTH);

	logic [CRED_W-1:0] credits_q;
	// Low for the first cycle out of reset while credits load
	logic link_up_q;

	// ****************************************
	// Credit counter
	// ****************************************

	always_ff @(posedge rvx_port_02 or negedge rvx_port_04)
	begin
		if (!rvx_port_04)
		begin
			credits_q <= CRED_MAX;
			link_up_q <= 1'b0;
			flit_valid <= 1'b0;
		end
		else
		begin
			link_up_q <= 1'b1;
			flit_valid <= send;
			// Spend on send, refill on return, both together cancel
			case ({send, credit_return})
				2'b10: credits_q <= credits_q - 1'b1;
				2'b01: credits_q <= credits_q + 1'b1;
				default: credits_q <= credits_q;
			endcase
		end
	end

	assign has_credit = link_up_q & (credits_q != '0);

	// Flit payload, only meaningful while flit_valid is high
	always_ff @(posedge rvx_port_02)
	begin
		if (send)
			flit <= send_flit;
	end

	// Sender must respect the credit count
	a_send_needs_credit: assert property (@(posedge rvx_port_02) disable iff (!rvx_port_04)
		send |-> has_credit)
		else $error("link_tx: send without credit");

	// Receiver can only return credits that were spent
	a_no_extra_credit: assert property (@(posedge rvx_port_02) disable iff (!rvx_port_04)
		credit_return |-> (credits_q != CRED_MAX))
		else $error("link_tx: credit returned while all credits held");

endmodule

/* src/link_rx.sv */
// Link receiver for one direction
// Circular FIFO of incoming flits; each pop hands one credit back
// to the transmitter on the following cycle

`timescale 1ns/1ps
`include "rab_defs.svh"

module link_rx
	import rab_pkg::*;
(
	input logic rvx_port_02,
	input logic rvx_port_04,
	input logic flit_valid,
	input rab_flit_u flit,
	input logic pop,
	output logic out_valid,
	output rab_flit_u out_flit,
	output logic credit_return
);

	localparam int PTR_W = $clog2(`RAB_LINK_DEPTH);
	localparam int CNT_W = $clog2(`RAB_LINK_DEPTH + 1);
	localparam logic [CNT_W-1:0] FULL = CNT_W'(`RAB_LINK_DEPTH);

	rab_flit_u mem [`RAB_LINK_DEPTH];
	logic [PTR_W-1:0] rd_ptr_q;
	logic [CNT_W-1:0] count_q;
	logic [PTR_W-1:0] wr_ptr;

	// Write slot sits count entries past the head
	// Power-of-two depth, so the add wraps on its own
	assign wr_ptr = rd_ptr_q + count_q[PTR_W-1:0];

	// ****************************************
	// Storage
	// ****************************************

	always_ff @(posedge rvx_port_02)
	begin
		if (flit_valid)
			mem[wr_ptr] <= flit;
	end

	// Head of queue
	assign out_valid = (count_q != '0);
	assign out_flit = mem[rd_ptr_q];

	// ****************************************
	// Pointer, count and credit pulse
	// ****************************************

	always_ff @(posedge rvx_port_02 or negedge rvx_port_04)
	begin
		if (!rvx_port_04)
		begin
			rd_ptr_q <= '0;
			count_q <= '0;
			credit_return <= 1'b0;
		end
		else
		begin
			credit_return <= pop;
			if (pop)
				rd_ptr_q <= rd_ptr_q + 1'b1;
			case ({flit_valid, pop})
				2'b10: count_q <= count_q + 1'b1;
				2'b01: count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

	// Credits bound the sender, so a full FIFO never sees a new flit
	a_no_overflow: assert property (@(posedge rvx_port_02) disable iff (!rvx_port_04)
		flit_valid |-> (count_q != FULL))
		else $error("link_rx: flit arrived while FIFO full");

	// Consumer pops only what it was shown
	a_no_underflow: assert property (@(posedge rvx_port_02) disable iff (!rvx_port_04)
		pop |-> out_valid)
		else $error("link_rx: pop while FIFO empty");

endmodule

/* src/req_bridge.sv */
// Client request bridge
// Takes one request when idle, sends it as a tagged flit on the request
// link, then waits for the response flit and hands it back as a
// one-cycle response pulse

`timescale 1ns/1ps
`include "rab_defs.svh"

module req_bridge
	import rab_pkg::*;
(
	input logic rvx_port_02,
	input logic rvx_port_04,
	input logic req_valid,
	input rab_req_t req,
	output logic req_ready,
	output logic rsp_valid,
	output rab_rsp_t rsp,
	input logic tx_has_credit,
	output logic tx_send,
	output rab_flit_u tx_flit,
	input logic rx_valid,
	input rab_flit_u rx_flit,
	output logic rx_pop
);

	localparam logic ST_IDLE = 1'b0;
	localparam logic ST_WAIT = 1'b1;

	logic state_q;
	logic [`RAB_TAG_W-1:0] tag_q;
	logic [`RAB_TAG_W-1:0] out_tag;
	logic accept;

	// ****************************************
	// Request side
	// ****************************************

	// Idle and a slot free on the link
	assign req_ready = (state_q == ST_IDLE) & tx_has_credit;
	assign accept = req_valid & req_ready;

	// Launch goes out in the accepting cycle
	assign tx_send = accept;

	always_comb
	begin
		tx_flit = '0;
		tx_flit.req.tag = tag_q;
		tx_flit.req.req = req;
	end

	// Two-state control plus the running sequence tag
	always_ff @(posedge rvx_port_02 or negedge rvx_port_04)
	begin
		if (!rvx_port_04)
		begin
			state_q <= ST_IDLE;
			tag_q <= '0;
		end
		else
		begin
			case (state_q)
				ST_IDLE:
					if (accept)
					begin
						state_q <= ST_WAIT;
						tag_q <= tag_q + 1'b1;
					end
				ST_WAIT:
					if (rx_valid)
						state_q <= ST_IDLE;
				default:
					state_q <= ST_IDLE;
			endcase
		end
	end

	// ****************************************
	// Response side
	// ****************************************

	// Response flits are drained the cycle they show up
	assign rx_pop = rx_valid;
	assign rsp_valid = rx_pop;
	assign rsp = rx_flit.rsp.rsp;

	// Tag of the request in flight, the counter has already moved on
	assign out_tag = tag_q - 1'b1;

	// Target must echo the tag of the single outstanding request
	a_rsp_tag_match: assert property (@(posedge rvx_port_02) disable iff (!rvx_port_04)
		rx_valid |-> (state_q == ST_WAIT) && (rx_flit.rsp.tag == out_tag))
		else $error("req_bridge: response tag %0h, expected %0h", rx_flit.rsp.tag, out_tag);

endmodule

/* src/scratch_bank.sv */
// Scratch register bank
// Eight general read/write registers with a registered read port

`timescale 1ns/1ps
`include "rab_defs.svh"

module scratch_bank
(
	input logic rvx_port_02,
	input logic rvx_port_04,
	input logic en,
	input logic wr,
	input logic [`RAB_IDX_W-2:0] idx,
	input logic [`RAB_DATA_W-1:0] wdata,
	output logic [`RAB_DATA_W-1:0] rdata
);

	logic [`RAB_DATA_W-1:0] regs_q [`RAB_SCRATCH_REGS];

	// ****************************************
	// Register file
	// ****************************************

	always_ff @(posedge rvx_port_02 or negedge rvx_port_04)
	begin
		if (!rvx_port_04)
		begin
			for (int i = 0; i < `RAB_SCRATCH_REGS; i++)
				regs_q[i] <= '0;
		end
		else if (en && wr)
		begin
			regs_q[idx] <= wdata;
		end
	end

	// Read port
	// Write returns the value just stored
	always_ff @(posedge rvx_port_02)
	begin
		if (en)
		begin
			if (wr)
				rdata <= wdata;
			else
				rdata <= regs_q[idx];
		end
	end

endmodule

/* src/event_bank.sv */
// Event counter bank
// Counts scratch writes, scratch reads, errors and all requests;
// a read samples a counter and a write clears it

`timescale 1ns/1ps
`include "rab_defs.svh"

module event_bank
(
	input logic rvx_port_02,
	input logic rvx_port_04,
	input logic en,
	input logic wr,
	input logic [`RAB_IDX_W-2:0] idx,
	input logic ev_write,
	input logic ev_read,
	input logic ev_err,
	output logic [`RAB_DATA_W-1:0] rdata,
	output logic err
);

	localparam int EV_REGS = 4;
	localparam int EV_SEL_W = $clog2(EV_REGS);

	logic [`RAB_DATA_W-1:0] cnt_q [EV_REGS];
	logic [EV_REGS-1:0] inc;
	logic in_range;

	// Only the lower half of the event window is mapped
	assign in_range = ~idx[`RAB_IDX_W-2];

	// Per-counter increment strobes
	// 0 scratch writes, 1 scratch reads, 2 errors, 3 every request
	assign inc[0] = ev_write;
	assign inc[1] = ev_read;
	assign inc[2] = ev_err;
	assign inc[3] = en | ev_write | ev_read;

	// ****************************************
	// Counters
	// ****************************************

	always_ff @(posedge rvx_port_02 or negedge rvx_port_04)
	begin
		if (!rvx_port_04)
		begin
			for (int i = 0; i < EV_REGS; i++)
				cnt_q[i] <= '0;
		end
		else
		begin
			for (int i = 0; i < EV_REGS; i++)
			begin
				// Clear wins over a same-cycle count
				if (en && wr && in_range && (idx[EV_SEL_W-1:0] == EV_SEL_W'(i)))
					cnt_q[i] <= '0;
				else if (inc[i])
					cnt_q[i] <= cnt_q[i] + 1'b1;
			end
		end
	end

	// Sample before this request's own events land
	always_ff @(posedge rvx_port_02)
	begin
		if (en)
		begin
			rdata <= in_range ? cnt_q[idx[EV_SEL_W-1:0]] : '0;
			err <= ~in_range;
		end
	end

endmodule

/* src/target_port.sv */
// Target port
// Pops request flits, steers each one to the scratch or event bank,
// and returns the bank result as a response flit one cycle later

`timescale 1ns/1ps
`include "rab_defs.svh"

module target_port
	import rab_pkg::*;
(
	input logic rvx_port_02,
	input logic rvx_port_04,
	input logic rx_valid,
	input rab_flit_u rx_flit,
	output logic rx_pop,
	input logic tx_has_credit,
	output logic tx_send,
	output rab_flit_u tx_flit
);

	rab_flit_req_t rq;
	logic bank_sel;
	logic [`RAB_IDX_W-2:0] idx_low;
	logic sc_en;
	logic ev_en;
	logic ev_write;
	logic ev_read;
	logic ev_err;

	// Request in its second cycle
	logic pend_q;
	logic sel_q;
	logic [`RAB_TAG_W-1:0] tag_q;

	logic [`RAB_DATA_W-1:0] sc_rdata;
	logic [`RAB_DATA_W-1:0] ev_rdata;
	logic ev_err_q;

	// ****************************************
	// Decode
	// ****************************************

	assign rq = rx_flit.req;
	assign bank_sel = rq.req.idx[`RAB_IDX_W-1];
	assign idx_low = rq.req.idx[`RAB_IDX_W-2:0];

	// One request at a time, and only with a response slot reserved
	assign rx_pop = rx_valid & tx_has_credit & ~pend_q;

	assign sc_en = rx_pop & ~bank_sel;
	assign ev_en = rx_pop & bank_sel;

	// Event strobes
	assign ev_write = sc_en & rq.req.wr;
	assign ev_read = sc_en & ~rq.req.wr;
	// Event indices 4 to 7 are unmapped
	assign ev_err = ev_en & idx_low[`RAB_IDX_W-2];

	// ****************************************
	// Banks
	// ****************************************

	scratch_bank u_scratch (
		.rvx_port_02(rvx_port_02),
		.rvx_port_04(rvx_port_04),
		.en(sc_en),
		.wr(rq.req.wr),
		.idx(idx_low),
		.wdata(rq.req.wdata),
		.rdata(sc_rdata)
	);

	event_bank u_event (
		.rvx_port_02(rvx_port_02),
		.rvx_port_04(rvx_port_04),
		.en(ev_en),
		.wr(rq.req.wr),
		.idx(idx_low),
		.ev_write(ev_write),
		.ev_read(ev_read),
		.ev_err(ev_err),
		.rdata(ev_rdata),
		.err(ev_err_q)
	);

	// ****************************************
	// Response
	// ****************************************

	always_ff @(posedge rvx_port_02 or negedge rvx_port_04)
	begin
		if (!rvx_port_04)
			pend_q <= 1'b0;
		else
			pend_q <= rx_pop;
	end

	// Remember tag and bank for the merge
	always_ff @(posedge rvx_port_02)
	begin
		if (rx_pop)
		begin
			tag_q <= rq.tag;
			sel_q <= bank_sel;
		end
	end

	// Credit seen at pop is still there, nothing else spends it
	assign tx_send = pend_q;

	always_comb
	begin
		tx_flit = '0;
		tx_flit.rsp.tag = tag_q;
		tx_flit.rsp.rsp.rdata = sel_q ? ev_rdata : sc_rdata;
		// Scratch bank never faults
		tx_flit.rsp.rsp.err = sel_q & ev_err_q;
	end

endmodule

/* src/rab_top.sv */
// Register-access subsystem top
// Bridge, request and response links, and the target port with its banks

`timescale 1ns/1ps

module rab_top
	import rab_pkg::*;
(
	input logic rvx_port_02,
	input logic rvx_port_04,
	input logic req_valid,
	input rab_req_t req,
	output logic req_ready,
	output logic rsp_valid,
	output rab_rsp_t rsp
);

	// Request direction
	logic rq_has_credit;
	logic rq_send;
	rab_flit_u rq_send_flit;
	logic rq_link_valid;
	rab_flit_u rq_link_flit;
	logic rq_credit;
	logic rq_out_valid;
	rab_flit_u rq_out_flit;
	logic rq_pop;

	// Response direction
	logic rs_has_credit;
	logic rs_send;
	rab_flit_u rs_send_flit;
	logic rs_link_valid;
	rab_flit_u rs_link_flit;
	logic rs_credit;
	logic rs_out_valid;
	rab_flit_u rs_out_flit;
	logic rs_pop;

	req_bridge u_bridge (
		.rvx_port_02(rvx_port_02),
		.rvx_port_04(rvx_port_04),
		.req_valid(req_valid),
		.req(req),
		.req_ready(req_ready),
		.rsp_valid(rsp_valid),
		.rsp(rsp),
		.tx_has_credit(rq_has_credit),
		.tx_send(rq_send),
		.tx_flit(rq_send_flit),
		.rx_valid(rs_out_valid),
		.rx_flit(rs_out_flit),
		.rx_pop(rs_pop)
	);

	// ****************************************
	// Request link
	// ****************************************

	link_tx u_req_tx (
		.rvx_port_02(rvx_port_02),
		.rvx_port_04(rvx_port_04),
		.send(rq_send),
		.send_flit(rq_send_flit),
		.credit_return(rq_credit),
		.has_credit(rq_has_credit),
		.flit_valid(rq_link_valid),
		.flit(rq_link_flit)
	);

	link_rx u_req_rx (
		.rvx_port_02(rvx_port_02),
		.rvx_port_04(rvx_port_04),
		.flit_valid(rq_link_valid),
		.flit(rq_link_flit),
		.pop(rq_pop),
		.out_valid(rq_out_valid),
		.out_flit(rq_out_flit),
		.credit_return(rq_credit)
	);

	target_port u_target (
		.rvx_port_02(rvx_port_02),
		.rvx_port_04(rvx_port_04),
		.rx_valid(rq_out_valid),
		.rx_flit(rq_out_flit),
		.rx_pop(rq_pop),
		.tx_has_credit(rs_has_credit),
		.tx_send(rs_send),
		.tx_flit(rs_send_flit)
	);

	// ****************************************
	// Response link
	// ****************************************

	link_tx u_rsp_tx (
		.rvx_port_02(rvx_port_02),
		.rvx_port_04(rvx_port_04),
		.send(rs_send),
		.send_flit(rs_send_flit),
		.credit_return(rs_credit),
		.has_credit(rs_has_credit),
		.flit_valid(rs_link_valid),
		.flit(rs_link_flit)
	);

	link_rx u_rsp_rx (
		.rvx_port_02(rvx_port_02),
		.rvx_port_04(rvx_port_04),
		.flit_valid(rs_link_valid),
		.flit(rs_link_flit),
		.pop(rs_pop),
		.out_valid(rs_out_valid),
		.out_flit(rs_out_flit),
		.credit_return(rs_credit)
	);

endmodule

/* sim/tb_clkgen.sv */
// Testbench clock and reset source
// Free-running clock and an active-low reset held for a few cycles

`timescale 1ns/1ps

module tb_clkgen #(
	parameter int PERIOD_NS = 40,
	parameter int RESET_CYCLES = 4
) (
	output logic rvx_port_02,
	output logic rvx_port_04
);

	// Clock, starts low
	initial
	begin
		rvx_port_02 = 1'b0;
		forever
		begin
			#(PERIOD_NS / 2);
			rvx_port_02 = ~rvx_port_02;
		end
	end

	// Reset low from time zero
	// Release lands just after an edge, clear of the sampling point
	initial
	begin
		rvx_port_04 = 1'b0;
		repeat (RESET_CYCLES) @(posedge rvx_port_02);
		#2;
		rvx_port_04 = 1'b1;
	end

endmodule

/* sim/tb_checker.sv */
// Testbench response checker
// Latches the expected result at each accepted request and compares
// it with the response pulse; prints one line per finished test

`timescale 1ns/1ps

module tb_checker
	import rab_pkg::*;
(
	input logic rvx_port_02,
	input logic rvx_port_04,
	input logic req_valid,
	input rab_req_t req,
	input logic req_ready,
	input logic rsp_valid,
	input rab_rsp_t rsp,
	input int row_id,
	input rab_rsp_t exp,
	output int pass_count,
	output int fail_count
);

	// Single outstanding expectation
	logic pending;
	int pend_row;
	rab_req_t pend_req;
	rab_rsp_t pend_exp;

	// ****************************************
	// Request side
	// ****************************************

	task automatic take_request();
		pending = 1'b1;
		pend_row = row_id;
		pend_req = req;
		pend_exp = exp;
	endtask

	// Bridge must hold off new requests while one is in flight
	task automatic check_ready_held();
		if (req_ready)
		begin
			$display("Error at %0t ns: bridge ready while row %0d still waits for a response",
				$time, pend_row);
			fail_count++;
		end
	endtask

	// ****************************************
	// Response side
	// ****************************************

	task automatic check_response();
		logic bad;
		bad = 1'b0;
		if (!pending)
		begin
			// Also catches a response pulse longer than one cycle
			$display("Error at %0t ns: response pulse with no request outstanding", $time);
			fail_count++;
		end
		else
		begin
			if (rsp.rdata !== pend_exp.rdata)
			begin
				$display("mismatch at %0t ns: rsp.rdata expected %08h actual %08h",
					$time, pend_exp.rdata, rsp.rdata);
				bad = 1'b1;
			end
			if (rsp.err !== pend_exp.err)
			begin
				$display("mismatch at %0t ns: rsp.err expected %0b actual %0b",
					$time, pend_exp.err, rsp.err);
				bad = 1'b1;
			end
			if (bad)
			begin
				$display("row %0d failed: %s idx %h", pend_row,
					pend_req.wr ? "write" : "read", pend_req.idx);
				fail_count++;
			end
			else
			begin
				$display("row %0d passed: %s idx %h data %08h err %0b", pend_row,
					pend_req.wr ? "write" : "read", pend_req.idx, rsp.rdata, rsp.err);
				pass_count++;
			end
			pending = 1'b0;
		end
	endtask

	// Falling edge, where DUT outputs and driven inputs are both settled
	always @(negedge rvx_port_02)
	begin
		if (!rvx_port_04)
		begin
			pending = 1'b0;
			pass_count = 0;
			fail_count = 0;
		end
		else
		begin
			// Response first so a finished wait clears before the ready check
			if (rsp_valid)
				check_response();
			if (pending)
				check_ready_held();
			if (req_valid && req_ready)
				take_request();
		end
	end

endmodule

/* sim/tb_top.sv */
// Register-access subsystem testbench
// Applies a fixed table of scratch and event-counter accesses one at a
// time and leaves the comparison to the checker

`timescale 1ns/1ps
`include "rab_defs.svh"

module tb_top
	import rab_pkg::*;
();

	localparam int PERIOD_NS = 40;
	localparam int RESET_CYCLES = 4;
	localparam int DRIVE_DLY = 2;
	localparam int N_ROWS = 19;
	// Generous budget per row, far above the 4-cycle minimum latency
	localparam int WATCHDOG_NS = (RESET_CYCLES + N_ROWS * 50) * PERIOD_NS;

	// One table row, request and expected response
	typedef struct packed {
		rab_req_t req;
		rab_rsp_t exp;
	} row_t;

	logic rvx_port_02;
	logic rvx_port_04;
	logic req_valid;
	rab_req_t req;
	logic req_ready;
	logic rsp_valid;
	rab_rsp_t rsp;
	rab_rsp_t exp;
	int row_id;
	int pass_count;
	int fail_count;
	row_t rows [N_ROWS];

	tb_clkgen #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(RESET_CYCLES)) u_clkgen (
		.rvx_port_02(rvx_port_02),
		.rvx_port_04(rvx_port_04)
	);

	rab_top u_dut (
		.rvx_port_02(rvx_port_02),
		.rvx_port_04(rvx_port_04),
		.req_valid(req_valid),
		.req(req),
		.req_ready(req_ready),
		.rsp_valid(rsp_valid),
		.rsp(rsp)
	);

	tb_checker u_checker (
		.rvx_port_02(rvx_port_02),
		.rvx_port_04(rvx_port_04),
		.req_valid(req_valid),
		.req(req),
		.req_ready(req_ready),
		.rsp_valid(rsp_valid),
		.rsp(rsp),
		.row_id(row_id),
		.exp(exp),
		.pass_count(pass_count),
		.fail_count(fail_count)
	);

	// ****************************************
	// Stimulus table
	// ****************************************

	function automatic row_t make_row(input logic wr, input logic [`RAB_IDX_W-1:0] idx,
		input logic [`RAB_DATA_W-1:0] wdata, input logic [`RAB_DATA_W-1:0] exp_data,
		input logic exp_err);
		row_t r;
		r.req.wr = wr;
		r.req.idx = idx;
		r.req.wdata = wdata;
		r.exp.rdata = exp_data;
		r.exp.err = exp_err;
		return r;
	endfunction

	// Counters c0 writes, c1 reads, c2 errors, c3 all requests
	// Reads sample before the row itself is counted
	task automatic load_table();
		rows[0] = make_row(1'b0, 4'h2, 32'h0, 32'h0000_0000, 1'b0);
		rows[1] = make_row(1'b1, 4'h3, 32'hA5A5_1234, 32'hA5A5_1234, 1'b0);
		rows[2] = make_row(1'b0, 4'h3, 32'h0, 32'hA5A5_1234, 1'b0);
		// Neighbour of a written register stays zero
		rows[3] = make_row(1'b0, 4'h2, 32'h0, 32'h0000_0000, 1'b0);
		rows[4] = make_row(1'b1, 4'h7, 32'hDEAD_BEEF, 32'hDEAD_BEEF, 1'b0);
		rows[5] = make_row(1'b0, 4'h7, 32'h0, 32'hDEAD_BEEF, 1'b0);
		// So far 2 writes, 4 reads, 6 requests
		rows[6] = make_row(1'b0, 4'h8, 32'h0, 32'd2, 1'b0);
		rows[7] = make_row(1'b0, 4'h9, 32'h0, 32'd4, 1'b0);
		rows[8] = make_row(1'b0, 4'hB, 32'h0, 32'd8, 1'b0);
		// Unmapped event slot 5
		rows[9] = make_row(1'b0, 4'hD, 32'h0, 32'h0000_0000, 1'b1);
		rows[10] = make_row(1'b0, 4'hA, 32'h0, 32'd1, 1'b0);
		// Clear of c1, returns the old count
		rows[11] = make_row(1'b1, 4'h9, 32'h1111_1111, 32'd4, 1'b0);
		rows[12] = make_row(1'b0, 4'h0, 32'h0, 32'h0000_0000, 1'b0);
		rows[13] = make_row(1'b0, 4'h9, 32'h0, 32'd1, 1'b0);
		// Clear of c3 beats its own increment
		rows[14] = make_row(1'b1, 4'hB, 32'h2222_2222, 32'd14, 1'b0);
		rows[15] = make_row(1'b1, 4'h0, 32'h0000_00FF, 32'h0000_00FF, 1'b0);
		// Write to unmapped slot 7 clears nothing
		rows[16] = make_row(1'b1, 4'hF, 32'h3333_3333, 32'h0000_0000, 1'b1);
		rows[17] = make_row(1'b0, 4'hB, 32'h0, 32'd2, 1'b0);
		rows[18] = make_row(1'b0, 4'hA, 32'h0, 32'd2, 1'b0);
	endtask

	// ****************************************
	// Drive loop
	// ****************************************

	// One row, hold valid until accepted, then wait for its response
	task automatic run_row(input int n);
		@(posedge rvx_port_02);
		#(DRIVE_DLY);
		row_id = n;
		req = rows[n].req;
		exp = rows[n].exp;
		req_valid = 1'b1;
		while (!req_ready)
		begin
			@(posedge rvx_port_02);
			#(DRIVE_DLY);
		end
		// Accepted on this edge
		@(posedge rvx_port_02);
		#(DRIVE_DLY);
		req_valid = 1'b0;
		while (!rsp_valid)
		begin
			@(posedge rvx_port_02);
			#(DRIVE_DLY);
		end
	endtask

	initial
	begin
		req_valid = 1'b0;
		req = '0;
		exp = '0;
		row_id = 0;
		load_table();
		wait (rvx_port_04 === 1'b1);
		for (int i = 0; i < N_ROWS; i++)
			run_row(i);
		// Let the checker see the last pulse
		repeat (2) @(posedge rvx_port_02);
		$display("Totals: %0d passed, %0d failed of %0d rows", pass_count, fail_count, N_ROWS);
		if (fail_count == 0 && pass_count == N_ROWS)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

	// Watchdog
	initial
	begin
		#(WATCHDOG_NS);
		$display("Timeout: rows did not complete within %0d ns", WATCHDOG_NS);
		$display("Test FAILED");
		$finish;
	end

endmodule

/* compile.f */
+incdir+src
src/rab_pkg.sv
src/link_tx.sv
src/link_rx.sv
src/req_bridge.sv
src/scratch_bank.sv
src/event_bank.sv
src/target_port.sv
src/rab_top.sv
sim/tb_clkgen.sv
sim/tb_checker.sv
sim/tb_top.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the register-access subsystem testbench with Verilator
# Exit status follows the pass line in sim.log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_top -f compile.f -o tb_sim \
	> build.log 2>&1 || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1 || echo "Simulation exited with an error status"
cat sim.log

grep -qx "Test OK" sim.log && { echo "PASS"; exit 0; } || { echo "FAIL, see sim.log"; exit 1; }
